// ==== verilog.f ====
+incdir+.
fetch_pkg.sv
fetch_ctrl_regs.sv
fetch_prefetch_buffer.sv
fetch_top.sv
tb_fetch_props.sv
tb_fetch_top.sv

// ==== Makefile ====
# Verilator flow for the fetch front end
VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module fetch_top

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_fetch_top.sv ====
`include "fetch_settings.svh"

module tb_fetch_top;
  import fetch_pkg::*;

  localparam int N_INSTR     = 224;                // All transfers waited for over the run
  localparam int CYCLE_LIMIT = 20 * N_INSTR + 200;

  logic                     clk = 1'b0;
  logic                     rst_n;
  cfg_wr_t                  cfg_wr;
  cfg_reg_e                 cfg_sel;
  logic [`FETCH_ADDR_W-1:0] cfg_rdata;
  logic                     ready;
  fetch_out_t               out;
  imem_req_t                imem_req;
  imem_rsp_t                imem_rsp;
  logic                     busy;

  integer      seed = 32'h6f9108b1;
  logic [31:0] mem [256];
  logic [31:0] rnd;
  int          ready_mode;                         // 0 always ready, 1 random, 2 held low
  int          errors, err_mark, checks, cycles, xfers, cnt, ccnt, total;
  logic [31:0] exp_addr;
  logic [31:0] exp_data;
  logic [15:0] lo;

  // Memory model state for the one request in flight
  logic        pend;
  logic [31:0] pend_addr;
  int          rv_wait, gnt_wait;
  logic        hold_rsp;                           // Memory answers nothing while set

  fetch_top i_fetch_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_wr_i    (cfg_wr),
    .cfg_sel_i   (cfg_sel),
    .cfg_rdata_o (cfg_rdata),
    .ready_i     (ready),
    .out_o       (out),
    .imem_req_o  (imem_req),
    .imem_rsp_i  (imem_rsp),
    .busy_o      (busy)
  );

  always #4 clk = ~clk;

  function automatic logic [15:0] half_at(input logic [31:0] addr);
    return addr[1] ? mem[addr[9:2]][31:16] : mem[addr[9:2]][15:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] got_v);
    checks++;
    assert (got_v === exp_v) else begin
      $display("ERR %0t %s expected %h got %h", $time, name, exp_v, got_v);
      errors++;
    end
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors - err_mark);
    err_mark = errors;
  endtask

  // Pulse the write strobe and restart the expected stream once the redirect pulse is up
  task automatic start_stream(input cfg_reg_e sel, input logic [31:0] wdata,
                              input logic [31:0] target);
    @(posedge clk);
    #1 cfg_wr = '{we: 1'b1, sel: sel, wdata: wdata};
    @(posedge clk);
    #1 cfg_wr.we = 1'b0;
    exp_addr = target;
    cnt      = 0;
    ccnt     = 0;
  endtask

  task automatic wait_xfers(input int n);
    int start;
    start = xfers;
    while (xfers - start < n) @(posedge clk);
  endtask

  //////////////////////////////
  // Memory model and decode consumer

  always @(negedge clk) begin
    if (!rst_n) begin
      pend = 1'b0;
    end else begin
      if (imem_rsp.rvalid) pend = 1'b0;           // Response handed over this cycle
      if (imem_req.req && imem_rsp.gnt) begin
        pend      = 1'b1;
        pend_addr = imem_req.addr;
        rv_wait   = $unsigned($random(seed)) % 4;
        gnt_wait  = $unsigned($random(seed)) % 4;
      end
    end
  end

  always @(posedge clk) begin
    #1;
    imem_rsp.rvalid = pend && rv_wait == 0 && !hold_rsp;
    imem_rsp.rdata  = imem_rsp.rvalid ? mem[pend_addr[9:2]] : 32'h0;
    if (pend && rv_wait > 0) rv_wait--;
    // A new grant only once the old response is out
    imem_rsp.gnt = (!pend || imem_rsp.rvalid) && gnt_wait == 0 && !hold_rsp;
    if (gnt_wait > 0) gnt_wait--;
    rnd   = $random(seed);
    ready = (ready_mode == 0) || (ready_mode == 1 && rnd[1:0] != 2'b00);
  end

  // Reference stream check on every transfer
  always @(negedge clk) begin
    if (rst_n && out.valid && ready) begin
      lo = half_at(exp_addr);
      exp_data = (lo[1:0] == 2'b11) ? {half_at(exp_addr + 2), lo} : {16'h0000, lo};
      check_value("out_o.addr", exp_addr, out.addr);
      check_value("out_o.rdata", exp_data, out.rdata);
      xfers++;
      cnt++;
      if (lo[1:0] != 2'b11) ccnt++;
      exp_addr = exp_addr + ((lo[1:0] == 2'b11) ? 4 : 2);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the instruction stream stopped early", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Test sequence

  initial begin
    cfg_wr     = '0;
    cfg_sel    = CFG_BOOT;
    ready      = 1'b0;
    ready_mode = 0;
    imem_rsp   = '0;
    rst_n      = 1'b0;
    pend       = 1'b0;
    rv_wait    = 0;
    gnt_wait   = 0;
    hold_rsp   = 1'b0;
    exp_addr   = '0;
    for (int i = 0; i < 256; i++) begin
      rnd = $random(seed);
      lo  = rnd[15:0];
      if (rnd[16]) lo[1:0] = 2'b11;                // Full instruction starts here
      else if (lo[1:0] == 2'b11) lo[1:0] = 2'b01;
      rnd    = $random(seed);
      mem[i] = {rnd[15:0], lo};
    end
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;

    repeat (4) begin
      @(negedge clk);
      check_value("imem_req_o.req", 0, imem_req.req);
      check_value("out_o.valid", 0, out.valid);
      check_value("busy_o", 0, busy);
    end
    check_value("cfg_rdata_o", `FETCH_BOOT_ADDR, cfg_rdata);
    report_test(1, "reset state");

    start_stream(CFG_ENABLE, 32'h1, `FETCH_BOOT_ADDR);
    wait_xfers(64);
    report_test(2, "aligned stream");

    start_stream(CFG_JUMP, 32'h0000_0106, 32'h0000_0106);  // Starts on a half-word
    wait_xfers(64);
    report_test(3, "misaligned and split");

    ready_mode = 1;
    wait_xfers(64);
    report_test(4, "back-pressure");

    // Freeze the memory once a request is out so the jump lands on a pending fetch
    @(negedge clk);
    while (!imem_req.req) @(negedge clk);
    hold_rsp = 1'b1;
    start_stream(CFG_JUMP, 32'h0000_0042, 32'h0000_0042);
    @(negedge clk);
    hold_rsp = 1'b0;                                // Stale response comes back after this
    wait_xfers(32);
    report_test(5, "redirect mid-stream");

    ready_mode = 2;
    repeat (4) @(posedge clk);
    #1 cfg_sel = CFG_COUNT;
    @(negedge clk);
    check_value("cfg_rdata_o", cnt, cfg_rdata);
    @(posedge clk);
    #1 cfg_sel = CFG_CCOUNT;
    @(negedge clk);
    check_value("cfg_rdata_o", ccnt, cfg_rdata);
    report_test(6, "counters");

    total = errors + i_fetch_top.i_fetch_prefetch_buffer.i_tb_fetch_props.fail_cnt;
    $display("tests 6, checks %0d, transfers %0d, errors %0d", checks, xfers, total);
    if (total == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== tb_fetch_props.sv ====
module tb_fetch_props (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  ready_i,
  input logic                  busy_o,
  input fetch_pkg::redirect_t  redirect_i,
  input fetch_pkg::fetch_out_t out_o,
  input fetch_pkg::imem_req_t  imem_req_o,
  input fetch_pkg::imem_rsp_t  imem_rsp_i
);

  int fail_cnt = 0;  // Read by the testbench for its final verdict

  // A stalled instruction stays put unless a redirect drops it
  stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_o.valid && !ready_i && !redirect_i.branch |=>
      redirect_i.branch || (out_o.valid && $stable(out_o.rdata) && $stable(out_o.addr)))
    else begin
      $error("decode output changed while stalled");
      fail_cnt++;
    end

  // Memory request is held with its address until granted
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    imem_req_o.req && !imem_rsp_i.gnt |=> imem_req_o.req && $stable(imem_req_o.addr))
    else begin
      $error("memory request dropped or moved before grant");
      fail_cnt++;
    end

  // Everything quiet in reset and in the first cycle after it
  reset_quiet: assert property (@(posedge clk)
    !rst_n |=> !imem_req_o.req && !out_o.valid && !busy_o && !redirect_i.branch)
    else begin
      $error("control output active during or right after reset");
      fail_cnt++;
    end

endmodule

bind fetch_prefetch_buffer tb_fetch_props i_tb_fetch_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .ready_i    (ready_i),
  .busy_o     (busy_o),
  .redirect_i (redirect_i),
  .out_o      (out_o),
  .imem_req_o (imem_req_o),
  .imem_rsp_i (imem_rsp_i)
);

// ==== fetch_top.sv ====
`include "fetch_settings.svh"

module fetch_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  fetch_pkg::cfg_wr_t       cfg_wr_i,
  input  fetch_pkg::cfg_reg_e      cfg_sel_i,
  output logic [`FETCH_ADDR_W-1:0] cfg_rdata_o,
  input  logic                     ready_i,
  output fetch_pkg::fetch_out_t    out_o,
  output fetch_pkg::imem_req_t     imem_req_o,
  input  fetch_pkg::imem_rsp_t     imem_rsp_i,
  output logic                     busy_o
);
  import fetch_pkg::*;

  logic      fetch_req;     // Enable level into the buffer
  redirect_t redirect;      // Boot or jump target with its pulse
  logic      delivered;
  logic      compressed;

  fetch_ctrl_regs i_fetch_ctrl_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_wr_i     (cfg_wr_i),
    .cfg_sel_i    (cfg_sel_i),
    .cfg_rdata_o  (cfg_rdata_o),
    .delivered_i  (delivered),
    .compressed_i (compressed),
    .fetch_req_o  (fetch_req),
    .redirect_o   (redirect)
  );

  fetch_prefetch_buffer i_fetch_prefetch_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_req_i  (fetch_req),
    .redirect_i   (redirect),
    .ready_i      (ready_i),
    .out_o        (out_o),
    .imem_req_o   (imem_req_o),
    .imem_rsp_i   (imem_rsp_i),
    .delivered_o  (delivered),
    .compressed_o (compressed),
    .busy_o       (busy_o)
  );

endmodule

// ==== fetch_prefetch_buffer.sv ====
`include "fetch_settings.svh"

module fetch_prefetch_buffer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fetch_req_i,  // Fetch enable level
  input  fetch_pkg::redirect_t  redirect_i,
  input  logic                  ready_i,      // Decode can take an instruction
  output fetch_pkg::fetch_out_t out_o,
  output fetch_pkg::imem_req_t  imem_req_o,
  input  fetch_pkg::imem_rsp_t  imem_rsp_i,
  output logic                  delivered_o,  // Transfer to decode this cycle
  output logic                  compressed_o, // The transferred instruction is compressed
  output logic                  busy_o
);
  import fetch_pkg::*;

  fetch_state_e             state_q, state_n;
  logic [`FETCH_ADDR_W-1:0] fetch_addr_q, fetch_addr_n;  // Address of the next instruction
  logic [`FETCH_ADDR_W-1:0] saved_addr_q, saved_addr_n;  // First address of a split instruction
  logic [`FETCH_ADDR_W-1:0] req_addr_q;                  // Word address held while waiting for gnt
  logic [15:0]              hw_q, hw_n;                  // Upper half of the last consumed word
  logic                     hw_valid_q, hw_valid_n;
  logic                     second_q, second_n;          // Outstanding fetch is the split upper half
  logic                     stalled_q, stalled_n;        // Word parked in the stall register
  logic                     discard_q, discard_n;        // Next rvalid belongs to a stale request
  logic [31:0]              stall_data_q;

  // Combinational signals
  logic [31:0]              data_mux;   // Memory data or the parked word
  logic [31:0]              rdata;
  instr_format_e            fmt;
  logic [`FETCH_ADDR_W-1:0] pc_next;    // Output of the one shared PC adder
  logic [`FETCH_ADDR_W-1:0] addr_mux;   // Address of a request issued this cycle
  logic [`FETCH_ADDR_W-1:0] word_addr;
  logic [`FETCH_ADDR_W-1:0] out_addr;
  logic                     out_valid;
  logic                     issue;      // New request starts this cycle

  assign data_mux  = stalled_q ? stall_data_q : imem_rsp_i.rdata;
  assign word_addr = {addr_mux[`FETCH_ADDR_W-1:2], 2'b00};

  // Only a full aligned word advances by four
  assign pc_next = fetch_addr_q + `FETCH_ADDR_W'((fmt == FULL_ALIGNED) ? 3'd4 : 3'd2);

  // Format follows from the state, the alignment and the low bits of the data
  always_comb begin
    if (state_q == IDLE) begin
      fmt = C_IN_REG;                                   // Only the half-word register is used
    end else if (second_q) begin
      fmt = SPLIT_IN_REG;
    end else if (!fetch_addr_q[1]) begin
      fmt = (data_mux[1:0] != 2'b11) ? C_ALIGNED : FULL_ALIGNED;
    end else begin
      fmt = (data_mux[17:16] != 2'b11) ? C_MISALIGNED : C_IN_REG;  // C_IN_REG starts a split
    end
  end

  // Build the outgoing instruction and fill unused upper bits with zeros
  always_comb begin
    case (fmt)
      C_ALIGNED:    rdata = {16'h0000, data_mux[15:0]};
      C_MISALIGNED: rdata = {16'h0000, data_mux[31:16]};
      C_IN_REG:     rdata = {16'h0000, hw_q};
      SPLIT_IN_REG: rdata = {data_mux[15:0], hw_q};
      default:      rdata = data_mux;
    endcase
  end

  //////////////////////////////
  // Memory FSM

  always_comb begin
    state_n      = state_q;
    fetch_addr_n = fetch_addr_q;
    saved_addr_n = saved_addr_q;
    hw_n         = hw_q;
    hw_valid_n   = hw_valid_q;
    second_n     = second_q;
    stalled_n    = stalled_q;
    discard_n    = discard_q;
    addr_mux     = fetch_addr_q;
    out_addr     = fetch_addr_q;
    out_valid    = 1'b0;
    issue        = 1'b0;

    // A redirect drops the buffered half-word and any split in progress
    if (redirect_i.branch) begin
      fetch_addr_n = redirect_i.addr;
      addr_mux     = redirect_i.addr;
      hw_valid_n   = 1'b0;
      second_n     = 1'b0;
      stalled_n    = 1'b0;
    end

    case (state_q)
      IDLE: begin
        second_n  = 1'b0;
        stalled_n = 1'b0;
        if (redirect_i.branch) begin
          issue = fetch_req_i;                          // First request in the pulse cycle
        end else if (fetch_req_i) begin
          if (hw_valid_q && fetch_addr_q[1]) begin      // Instruction starts in the register
            addr_mux = pc_next;
            if (hw_q[1:0] != 2'b11) begin
              out_valid = 1'b1;                         // Compressed, no memory access needed
              if (ready_i) fetch_addr_n = pc_next;
            end else begin
              second_n     = 1'b1;                      // Split, fetch the upper half
              saved_addr_n = fetch_addr_q;
              fetch_addr_n = pc_next;
              issue        = 1'b1;
            end
          end else begin
            issue = 1'b1;
          end
        end
      end

      WAIT_GNT: begin
        if (redirect_i.branch) discard_n = 1'b1;        // Request stays up but its data is stale
        if (imem_rsp_i.gnt) state_n = WAIT_RVALID;
      end

      WAIT_RVALID: begin
        if (discard_q) begin
          if (imem_rsp_i.rvalid) begin                  // Swallow the stale response
            discard_n = 1'b0;
            state_n   = IDLE;
          end
        end else if (redirect_i.branch) begin
          if (imem_rsp_i.rvalid || stalled_q) begin
            state_n = IDLE;
            issue   = fetch_req_i;                      // Nothing outstanding, jump right away
          end else begin
            discard_n = 1'b1;
          end
        end else if (imem_rsp_i.rvalid || stalled_q) begin
          addr_mux = pc_next;
          out_addr = second_q ? saved_addr_q : fetch_addr_q;
          if (fmt == C_IN_REG) begin
            // Lower half of a split is known and the upper half is fetched even under stall
            hw_n         = data_mux[31:16];
            hw_valid_n   = 1'b1;
            second_n     = 1'b1;
            stalled_n    = 1'b0;
            saved_addr_n = fetch_addr_q;
            fetch_addr_n = pc_next;
            issue        = 1'b1;
          end else begin
            out_valid = 1'b1;
            if (ready_i) begin
              hw_n         = data_mux[31:16];
              hw_valid_n   = 1'b1;
              second_n     = 1'b0;
              stalled_n    = 1'b0;
              fetch_addr_n = pc_next;
              if (fmt == FULL_ALIGNED || fmt == C_MISALIGNED) begin
                issue = 1'b1;                           // Word used up, fetch the next one
              end else begin
                state_n = IDLE;                         // Upper half waits in the register
              end
            end else begin
              stalled_n = 1'b1;                         // Park the word until decode is ready
            end
          end
        end
      end

      default: state_n = IDLE;
    endcase

    if (issue) state_n = imem_rsp_i.gnt ? WAIT_RVALID : WAIT_GNT;
  end

  //////////////////////////////
  // Registers

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      fetch_addr_q <= '0;
      hw_valid_q   <= 1'b0;
      second_q     <= 1'b0;
      stalled_q    <= 1'b0;
      discard_q    <= 1'b0;
    end else begin
      state_q      <= state_n;
      fetch_addr_q <= fetch_addr_n;
      hw_valid_q   <= hw_valid_n;
      second_q     <= second_n;
      stalled_q    <= stalled_n;
      discard_q    <= discard_n;
    end
  end

  always_ff @(posedge clk) begin
    hw_q         <= hw_n;
    saved_addr_q <= saved_addr_n;
    if (issue) req_addr_q <= word_addr;                 // Keeps addr stable until gnt
    if (imem_rsp_i.rvalid && !stalled_q) stall_data_q <= imem_rsp_i.rdata;
  end

  // While waiting for gnt the held address wins even after a redirect
  assign imem_req_o = '{req:  issue | (state_q == WAIT_GNT),
                        addr: (state_q == WAIT_GNT) ? req_addr_q : word_addr};

  assign out_o = '{valid: out_valid, rdata: rdata, addr: out_addr};

  assign delivered_o  = out_valid & ready_i;
  assign compressed_o = delivered_o & (rdata[1:0] != 2'b11);
  assign busy_o       = (state_q != IDLE) | imem_req_o.req;

endmodule

// ==== fetch_ctrl_regs.sv ====
`include "fetch_settings.svh"

module fetch_ctrl_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  input  fetch_pkg::cfg_wr_t       cfg_wr_i,      // Single-cycle write strobe
  input  fetch_pkg::cfg_reg_e      cfg_sel_i,     // Readback selector
  output logic [`FETCH_ADDR_W-1:0] cfg_rdata_o,
  input  logic                     delivered_i,
  input  logic                     compressed_i,
  output logic                     fetch_req_o,
  output fetch_pkg::redirect_t     redirect_o
);
  import fetch_pkg::*;

  logic [`FETCH_ADDR_W-1:0] boot_q;
  logic                     enable_q;
  logic                     branch_q;   // Redirect pulse
  logic [`FETCH_ADDR_W-1:0] target_q;   // Redirect target
  logic [`FETCH_CNT_W-1:0]  cnt_q;      // Delivered instructions
  logic [`FETCH_CNT_W-1:0]  ccnt_q;     // Delivered compressed instructions

  // Counters stick at their maximum
  function automatic logic [`FETCH_CNT_W-1:0] sat_inc(input logic [`FETCH_CNT_W-1:0] v);
    return (&v) ? v : v + `FETCH_CNT_W'(1);
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      boot_q   <= `FETCH_BOOT_ADDR;
      enable_q <= 1'b0;
      branch_q <= 1'b0;
    end else begin
      branch_q <= 1'b0;
      if (cfg_wr_i.we) begin
        case (cfg_wr_i.sel)
          CFG_BOOT: boot_q <= cfg_wr_i.wdata;
          CFG_ENABLE: begin
            enable_q <= cfg_wr_i.wdata[0];
            branch_q <= cfg_wr_i.wdata[0] & ~enable_q;  // Rising enable starts at boot
          end
          CFG_JUMP: branch_q <= 1'b1;
          default: ;                                    // Counters ignore writes
        endcase
      end
    end
  end

  // Target is captured at the write edge and shows with the pulse one cycle later
  always_ff @(posedge clk) begin
    if (cfg_wr_i.we && cfg_wr_i.sel == CFG_JUMP) target_q <= cfg_wr_i.wdata;
    else if (cfg_wr_i.we && cfg_wr_i.sel == CFG_ENABLE) target_q <= boot_q;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      ccnt_q <= '0;
    end else if (branch_q) begin                        // A new stream restarts the counts
      cnt_q  <= '0;
      ccnt_q <= '0;
    end else if (delivered_i) begin
      cnt_q <= sat_inc(cnt_q);
      if (compressed_i) ccnt_q <= sat_inc(ccnt_q);
    end
  end

  always_comb begin
    case (cfg_sel_i)
      CFG_BOOT:   cfg_rdata_o = boot_q;
      CFG_ENABLE: cfg_rdata_o = `FETCH_ADDR_W'(enable_q);
      CFG_COUNT:  cfg_rdata_o = `FETCH_ADDR_W'(cnt_q);
      CFG_CCOUNT: cfg_rdata_o = `FETCH_ADDR_W'(ccnt_q);
      default:    cfg_rdata_o = '0;                     // Jump register has no readback
    endcase
  end

  assign fetch_req_o = enable_q;
  assign redirect_o  = '{branch: branch_q, addr: target_q};

endmodule

// ==== fetch_pkg.sv ====
`include "fetch_settings.svh"

package fetch_pkg;

  // Memory side of the prefetch buffer
  typedef enum logic [1:0] {IDLE, WAIT_GNT, WAIT_RVALID} fetch_state_e;

  // Where the outgoing instruction comes from
  typedef enum logic [2:0] {
    FULL_ALIGNED,   // Whole word from memory
    C_ALIGNED,      // Lower half of the word is a compressed instruction
    C_MISALIGNED,   // Upper half of the word is a compressed instruction
    C_IN_REG,       // Half-word register alone, or the first half of a split
    SPLIT_IN_REG    // Lower half in the register and upper half from memory
  } instr_format_e;

  // Configuration register selector
  typedef enum logic [2:0] {CFG_BOOT, CFG_ENABLE, CFG_JUMP, CFG_COUNT, CFG_CCOUNT} cfg_reg_e;

  //////////////////////////////
  // Port bundles

  typedef struct packed {
    logic                     req;
    logic [`FETCH_ADDR_W-1:0] addr;    // Always word aligned
  } imem_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } imem_rsp_t;

  typedef struct packed {
    logic                     branch;  // One-cycle pulse
    logic [`FETCH_ADDR_W-1:0] addr;
  } redirect_t;

  typedef struct packed {
    logic                     valid;
    logic [31:0]              rdata;
    logic [`FETCH_ADDR_W-1:0] addr;
  } fetch_out_t;

  typedef struct packed {
    logic                     we;      // Single-cycle write strobe
    cfg_reg_e                 sel;
    logic [`FETCH_ADDR_W-1:0] wdata;
  } cfg_wr_t;

endpackage

// ==== fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Width of every byte address in the fetch path
`define FETCH_ADDR_W 32

// Boot register value after reset
`define FETCH_BOOT_ADDR 32'h0000_0080

// Width of the delivered and compressed instruction counters
`define FETCH_CNT_W 16

`endif
